// ==== common/core_pkg.sv ====
// shared types for the rv32i core, imported by every rtl module with a wildcard import
package core_pkg;

	// data and address width
	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t;

	// major opcodes the core executes
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		// lui result is operand b as is
		alu_pass_b
	} alu_op_e;

	typedef enum logic {
		src_a_rs1,
		src_a_pc
	} src_a_e;

	typedef enum logic [1:0] {
		src_b_rs2,
		src_b_imm,
		src_b_four
	} src_b_e;

	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_jal,
		pc_jalr
	} pc_mode_e;

	// instruction format views, msb first
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, immediate bits differ per format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef struct packed {
		reg_idx_t          rd;
		reg_idx_t          rs1;
		reg_idx_t          rs2;
		logic [xlen-1:0]   imm;
	} decoded_t;

	typedef struct packed {
		alu_op_e    alu_op;
		src_a_e     src_a;
		src_b_e     src_b;
		logic       reg_write;
		pc_mode_e   pc_mode;
		logic [2:0] branch_funct3;
	} ctrl_t;

endpackage

// ==== decode/inst_decode.sv ====
// instruction field decoder, gives register indices and the sign-extended immediate
`timescale 1ns/1ps

module inst_decode
	import core_pkg::*;
(
	input  inst_u    inst,
	output decoded_t dec
);

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	// immediates of every format, built in parallel
	always_comb begin
		// i type, bit 31 is the sign
		imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
		// b type, offset in halfwords so bit 0 is zero
		imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
			inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
		// u type fills the upper 20 bits
		imm_u = {inst.u.imm_31_12, 12'b0};
		// j type, scrambled like b but wider
		imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
			inst.j.imm_11, inst.j.imm_10_1, 1'b0};
	end

	// register indices sit at fixed bits in every format
	always_comb begin
		dec.rd  = inst.r.rd;
		dec.rs1 = inst.r.rs1;
		// rs2 position shared by r, s and b formats
		dec.rs2 = inst.s.rs2;
	end

	// pick the immediate by major opcode
	always_comb begin
		case (inst.r.opcode)
			opc_op_imm,
			opc_jalr: begin
				dec.imm = imm_i;
			end
			opc_lui,
			opc_auipc: begin
				dec.imm = imm_u;
			end
			opc_jal: begin
				dec.imm = imm_j;
			end
			opc_branch: begin
				dec.imm = imm_b;
			end
			// register-register and anything unsupported
			default: begin
				dec.imm = '0;
			end
		endcase
	end

endmodule

// ==== decode/core_controller.sv ====
// main control unit, maps opcode and function bits to alu, operand and pc control
`timescale 1ns/1ps

module core_controller
	import core_pkg::*;
(
	input  inst_u inst,
	output ctrl_t ctrl
);

	logic [2:0] funct3;
	// funct7 bit 5, the alternate-operation bit
	logic       alt;
	logic       shift_alt;

	// funct3 to alu operation, alt picks sub or sra
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt_bit);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt_bit ? alu_sub : alu_add;
			3'b001:  op = alu_sll;
			3'b010:  op = alu_slt;
			3'b011:  op = alu_sltu;
			3'b100:  op = alu_xor;
			3'b101:  op = alt_bit ? alu_sra : alu_srl;
			3'b110:  op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	assign funct3 = inst.r.funct3;
	assign alt    = inst.r.funct7[5];
	// immediate ops only honour alt for right shifts
	assign shift_alt = alt && (funct3 == 3'b101);

	always_comb begin
		// defaults behave as a no-op with pc+4
		ctrl.alu_op        = alu_add;
		ctrl.src_a         = src_a_rs1;
		ctrl.src_b         = src_b_rs2;
		ctrl.reg_write     = 1'b0;
		ctrl.pc_mode       = pc_seq;
		ctrl.branch_funct3 = inst.b.funct3;
		case (inst.r.opcode)
			opc_op: begin
				ctrl.alu_op    = alu_from_funct3(funct3, alt);
				ctrl.reg_write = 1'b1;
			end
			opc_op_imm: begin
				ctrl.alu_op    = alu_from_funct3(funct3, shift_alt);
				ctrl.src_b     = src_b_imm;
				ctrl.reg_write = 1'b1;
			end
			opc_lui: begin
				ctrl.alu_op    = alu_pass_b;
				ctrl.src_b     = src_b_imm;
				ctrl.reg_write = 1'b1;
			end
			opc_auipc: begin
				ctrl.src_a     = src_a_pc;
				ctrl.src_b     = src_b_imm;
				ctrl.reg_write = 1'b1;
			end
			// jumps link pc+4 through the alu
			opc_jal: begin
				ctrl.src_a     = src_a_pc;
				ctrl.src_b     = src_b_four;
				ctrl.reg_write = 1'b1;
				ctrl.pc_mode   = pc_jal;
			end
			opc_jalr: begin
				ctrl.src_a     = src_a_pc;
				ctrl.src_b     = src_b_four;
				ctrl.reg_write = 1'b1;
				ctrl.pc_mode   = pc_jalr;
			end
			// compare done outside the alu op, nothing written
			opc_branch: begin
				ctrl.pc_mode = pc_branch;
			end
			default: begin
				ctrl.reg_write = 1'b0;
			end
		endcase
	end

endmodule

// ==== hdl/register_file.sv ====
// integer register file, 32 x xlen, two async read ports and one clocked write port
`timescale 1ns/1ps

module register_file
	import core_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  reg_idx_t        raddr1,
	input  reg_idx_t        raddr2,
	output logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] rdata2,
	input  logic            we,
	input  reg_idx_t        waddr,
	input  logic [xlen-1:0] wdata
);

	logic [xlen-1:0] regs [32];

	// all registers cleared while reset is high
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			// x0 never written
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/alu.sv ====
// alu with operand muxes, plus the branch comparator on the two register values
`timescale 1ns/1ps

module alu
	import core_pkg::*;
(
	input  ctrl_t           ctrl,
	input  logic [xlen-1:0] rdata1,
	input  logic [xlen-1:0] rdata2,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] pc,
	output logic [xlen-1:0] result,
	output logic            branch_taken
);

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic            eq;
	logic            lt;
	logic            ltu;

	// operand a is rs1 or the pc
	assign op_a = (ctrl.src_a == src_a_pc) ? pc : rdata1;

	always_comb begin
		case (ctrl.src_b)
			src_b_rs2: op_b = rdata2;
			src_b_imm: op_b = imm;
			// link address offset
			default:   op_b = 32'd4;
		endcase
	end

	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			alu_add:  result = op_a + op_b;
			alu_sub:  result = op_a - op_b;
			alu_sll:  result = op_a << shamt;
			alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
			alu_sltu: result = {31'b0, op_a < op_b};
			alu_xor:  result = op_a ^ op_b;
			alu_srl:  result = op_a >> shamt;
			alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
			alu_or:   result = op_a | op_b;
			alu_and:  result = op_a & op_b;
			default:  result = op_b;
		endcase
	end

	// branch compare always on the raw register values
	assign eq  = (rdata1 == rdata2);
	assign lt  = ($signed(rdata1) < $signed(rdata2));
	assign ltu = (rdata1 < rdata2);

	always_comb begin
		case (ctrl.branch_funct3)
			3'b000:  branch_taken = eq;
			3'b001:  branch_taken = !eq;
			3'b100:  branch_taken = lt;
			3'b101:  branch_taken = !lt;
			3'b110:  branch_taken = ltu;
			3'b111:  branch_taken = !ltu;
			// 010 and 011 are not branches
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== hdl/next_pc.sv ====
// program counter register and next-pc selection for sequential, branch and jump flow
`timescale 1ns/1ps

module next_pc
	import core_pkg::*;
#(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  pc_mode_e        pc_mode,
	input  logic            branch_taken,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] pc
);

	logic [xlen-1:0] pc_plus4;
	// pc-relative target for jal and branches
	logic [xlen-1:0] pc_target;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] jalr_target;
	logic [xlen-1:0] pc_next;

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + imm;
	assign jalr_sum  = rdata1 + imm;
	// jalr drops bit 0 of the sum
	assign jalr_target = {jalr_sum[xlen-1:1], 1'b0};

	always_comb begin
		case (pc_mode)
			pc_branch: begin
				pc_next = branch_taken ? pc_target : pc_plus4;
			end
			pc_jal: begin
				pc_next = pc_target;
			end
			pc_jalr: begin
				pc_next = jalr_target;
			end
			default: begin
				pc_next = pc_plus4;
			end
		endcase
	end

	// held at the reset vector until the first edge with reset low
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== hdl/core_top.sv ====
// single-cycle rv32i core top level, fetches inst for pc each cycle and exposes a write-back trace
`timescale 1ns/1ps

module core_top
	import core_pkg::*;
#(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] inst,
	output logic [xlen-1:0] pc,
	output logic            wb_valid,
	output reg_idx_t        wb_rd,
	output logic [xlen-1:0] wb_data
);

	inst_u           inst_word;
	decoded_t        dec;
	ctrl_t           ctrl;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] result;
	logic            branch_taken;

	assign inst_word = inst;

	inst_decode i_inst_decode (
		.inst (inst_word),
		.dec  (dec)
	);

	core_controller i_core_controller (
		.inst (inst_word),
		.ctrl (ctrl)
	);

	// alu result is the only write-back source
	register_file i_register_file (
		.clk    (clk),
		.reset  (reset),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (ctrl.reg_write),
		.waddr  (dec.rd),
		.wdata  (result)
	);

	alu i_alu (
		.ctrl         (ctrl),
		.rdata1       (rdata1),
		.rdata2       (rdata2),
		.imm          (dec.imm),
		.pc           (pc),
		.result       (result),
		.branch_taken (branch_taken)
	);

	next_pc #(
		.reset_pc (reset_pc)
	) i_next_pc (
		.clk          (clk),
		.reset        (reset),
		.pc_mode      (ctrl.pc_mode),
		.branch_taken (branch_taken),
		.imm          (dec.imm),
		.rdata1       (rdata1),
		.pc           (pc)
	);

	// trace of the write landing at the next edge, x0 writes hidden
	assign wb_valid = ctrl.reg_write && !reset && (dec.rd != '0);
	assign wb_rd    = dec.rd;
	assign wb_data  = result;

endmodule

// ==== bench/core_model.sv ====
// reference model of the rv32i core, steps architectural registers and pc one instruction at a time
package core_model;

	// architectural state, x0 never written
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;

	function automatic void reset_state(input logic [31:0] start_pc);
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		model_pc = start_pc;
	endfunction

	// integer operation by funct3, alt picks sub and sra
	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// branch condition by funct3
	function automatic logic branch_holds(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			3'b111:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// expected trace for the word at model_pc, then commit the state
	function automatic void step(input logic [31:0] word, output logic exp_valid,
		output logic [4:0] exp_rd, output logic [31:0] exp_data);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] next;
		logic [31:0] data;
		logic        write;
		rd = word[11:7];
		f3 = word[14:12];
		a = model_regs[word[19:15]];
		b = model_regs[word[24:20]];
		imm_i = {{20{word[31]}}, word[31:20]};
		imm_u = {word[31:12], 12'b0};
		imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		// unsupported words fall through as a no-op
		next = model_pc + 32'd4;
		data = '0;
		write = 1'b0;
		case (word[6:0])
			7'b0110011: begin
				data = alu_result(f3, word[30], a, b);
				write = 1'b1;
			end
			7'b0010011: begin
				// only srai uses the alt bit
				data = alu_result(f3, word[30] && (f3 == 3'b101), a, imm_i);
				write = 1'b1;
			end
			7'b0110111: begin
				data = imm_u;
				write = 1'b1;
			end
			7'b0010111: begin
				data = model_pc + imm_u;
				write = 1'b1;
			end
			7'b1101111: begin
				data = model_pc + 32'd4;
				write = 1'b1;
				next = model_pc + imm_j;
			end
			7'b1100111: begin
				data = model_pc + 32'd4;
				write = 1'b1;
				next = (a + imm_i) & ~32'd1;
			end
			7'b1100011: begin
				if (branch_holds(f3, a, b)) begin
					next = model_pc + imm_b;
				end
			end
			default: begin
				write = 1'b0;
			end
		endcase
		exp_valid = write && (rd != 5'd0);
		exp_rd = rd;
		exp_data = data;
		if (exp_valid) begin
			model_regs[rd] = data;
		end
		model_pc = next;
	endfunction

endpackage

// ==== bench/core_tb.sv ====
// simulation top that checks the rv32i core trace against the model on random instructions
`timescale 1ns/1ps

module core_tb
	import core_model::*;
();

	localparam logic [31:0] seed = 32'd59;
	localparam int num_inst = 2000;
	localparam int reset_cycles = 3;
	// run length plus a margin of spare cycles
	localparam int timeout_cycles = reset_cycles + num_inst + 97;

	logic        clk;
	logic        reset;
	logic [31:0] inst;
	logic [31:0] dut_pc;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	logic [31:0] rng_state;
	int          cycles = 0;
	int          pc_errors = 0;
	int          valid_errors = 0;
	int          rd_errors = 0;
	int          data_errors = 0;

	core_top i_core_top (
		.clk      (clk),
		.reset    (reset),
		.inst     (inst),
		.pc       (dut_pc),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// xorshift32 generator
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic is_supported(input logic [6:0] opc);
		logic hit;
		case (opc)
			7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111,
			7'b1101111, 7'b1100111, 7'b1100011: hit = 1'b1;
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

	// class first and then the random fields
	function automatic logic [31:0] random_instruction();
		logic [31:0] w;
		logic [31:0] r;
		logic [2:0]  kind;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        alt;
		logic [11:0] imm12;
		logic [6:0]  opc;
		logic [31:0] word;
		w = next_random();
		r = next_random();
		kind = r[2:0];
		rd = w[11:7];
		rs1 = w[19:15];
		rs2 = w[24:20];
		f3 = w[14:12];
		alt = r[3];
		// x0 as destination now and then
		if (r[7:4] == 4'd0) begin
			rd = 5'd0;
		end
		// same source twice so eq branches get taken
		if (r[11:8] == 4'd0) begin
			rs2 = rs1;
		end
		case (kind)
			3'd0: begin
				// alt only on add/sub and srl/sra
				if ((f3 != 3'b000) && (f3 != 3'b101)) begin
					alt = 1'b0;
				end
				word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
			end
			3'd1: begin
				imm12 = w[31:20];
				if (f3 == 3'b001) begin
					imm12 = {7'b0, w[24:20]};
				end else if (f3 == 3'b101) begin
					imm12 = {1'b0, alt, 5'b0, w[24:20]};
				end
				word = {imm12, rs1, f3, rd, 7'b0010011};
			end
			3'd2: word = {w[31:12], rd, 7'b0110111};
			3'd3: word = {w[31:12], rd, 7'b0010111};
			// j offsets are even by encoding
			3'd4: word = {w[31:12], rd, 7'b1101111};
			// jalr offset bit 0 forced low
			3'd5: word = {w[31:21], 1'b0, rs1, 3'b000, rd, 7'b1100111};
			3'd6: begin
				f3 = r[14:12];
				// 010 and 011 moved onto blt and bge
				if ((f3 == 3'b010) || (f3 == 3'b011)) begin
					f3 = f3 + 3'd2;
				end
				word = {w[31:25], rs2, rs1, f3, w[11:7], 7'b1100011};
			end
			default: begin
				opc = w[6:0];
				while (is_supported(opc)) begin
					opc = opc + 7'd1;
				end
				word = {w[31:7], opc};
			end
		endcase
		return word;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp, inout int count);
		assert (got === exp) else begin
			count++;
			$display("Error at %0t: %s dut %h expected %h", $time, name, got, exp);
		end
	endtask

	// pc against the model and then the trace for the word in flight
	task automatic check_cycle();
		logic        exp_valid;
		logic [4:0]  exp_rd;
		logic [31:0] exp_data;
		compare_word("pc", dut_pc, model_pc, pc_errors);
		step(inst, exp_valid, exp_rd, exp_data);
		compare_word("wb_valid", {31'b0, wb_valid}, {31'b0, exp_valid}, valid_errors);
		if (exp_valid) begin
			compare_word("wb_rd", {27'b0, wb_rd}, {27'b0, exp_rd}, rd_errors);
			compare_word("wb_data", wb_data, exp_data, data_errors);
		end
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		rng_state = seed;
		reset_state(32'd0);
		// addi x1, x0, 1 must stay off the trace during reset
		inst = 32'h00100093;
		@(posedge clk);
		repeat (reset_cycles - 1) begin
			#3;
			compare_word("pc", dut_pc, 32'd0, pc_errors);
			compare_word("wb_valid", {31'b0, wb_valid}, 32'd0, valid_errors);
			@(posedge clk);
		end
		#1;
		reset = 1'b0;
		// one instruction per cycle and its check 1 ns before the edge
		for (int n = 0; n < num_inst; n++) begin
			inst = random_instruction();
			#2;
			check_cycle();
			@(posedge clk);
			#1;
		end
		$display("errors: pc %0d, wb_valid %0d, wb_rd %0d, wb_data %0d",
			pc_errors, valid_errors, rd_errors, data_errors);
		if (pc_errors + valid_errors + rd_errors + data_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== core_top.f ====
common/core_pkg.sv
decode/inst_decode.sv
decode/core_controller.sv
hdl/register_file.sv
hdl/alu.sv
hdl/next_pc.sv
hdl/core_top.sv
bench/core_model.sv
bench/core_tb.sv

// ==== Bender.yml ====
package:
  name: core_top

sources:
  - common/core_pkg.sv
  - decode/inst_decode.sv
  - decode/core_controller.sv
  - hdl/register_file.sv
  - hdl/alu.sv
  - hdl/next_pc.sv
  - hdl/core_top.sv
  - target: simulation
    files:
      - bench/core_model.sv
      - bench/core_tb.sv
